//--- irom.hex
// one 32-bit instruction word per line, word address 0 first
02800404
0280080c
00150085
02bffc84
5c000c85
28c00086
29c00087
0040a0c6
00109cc6
50001000
02801008
28800109
0380000a
0015014b
6400100c
00150d8d
1c00000e
0280400f
02ff8210
00104211
29800212
4c000020
00150013
28c00214
0280a615
58000c96
02800417
00105af8
002a0000
0340a719
28c0033a
4c00001b

//--- files.f
design/cpu7_pkg.sv
design/cpu7_ifu_fdp.sv
design/cpu7_ifu_ibus.sv
design/cpu7_irom.sv
design/cpu7_ifu_pcpipe.sv
design/cpu7_ifu.sv
bench/tb_clock_gen.sv
bench/cpu7_ifu_props.sv
bench/cpu7_ifu_tb.sv

//--- run.sh
#!/bin/sh
# build and run the fetch unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f files.f --top-module cpu7_ifu_tb -o cpu7_ifu_sim
status=$?
if [ $status -ne 0 ]; then
   echo "build failed with status $status"
   exit 1
fi

./obj_dir/cpu7_ifu_sim +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^RESULT: PASS$" sim.log; then
   echo "test passed"
   exit 0
else
   echo "pass message not found in sim.log"
   exit 1
fi

//--- bench/cpu7_ifu_tb.sv
`timescale 1ns/100ps

module cpu7_ifu_tb;

   import cpu7_pkg::*;

   // ============================================================
   // stimulus table
   // ============================================================

   // row kinds
   localparam logic [2:0] k_none  = 3'd0;
   localparam logic [2:0] k_br    = 3'd1;
   localparam logic [2:0] k_exc   = 3'd2;
   localparam logic [2:0] k_ertn  = 3'd3;
   localparam logic [2:0] k_stall = 3'd4;
   localparam logic [2:0] k_both  = 3'd5;
   localparam int n_rows = 28;

   // kind, random target flag, fixed target
   typedef struct packed {
      logic [2:0]       kind;
      logic             rnd;
      logic [grlen-1:0] addr;
   } row_t;

   row_t rows [n_rows] = '{
      '{k_none, 1'b0, 32'h0}, '{k_none, 1'b0, 32'h0},
      '{k_none, 1'b0, 32'h0}, '{k_none, 1'b0, 32'h0},
      // branch and run on from the target
      '{k_br, 1'b1, 32'h0}, '{k_none, 1'b0, 32'h0}, '{k_none, 1'b0, 32'h0},
      // two stall cycles
      '{k_stall, 1'b0, 32'h0}, '{k_stall, 1'b0, 32'h0}, '{k_none, 1'b0, 32'h0},
      '{k_exc, 1'b1, 32'h0}, '{k_none, 1'b0, 32'h0},
      '{k_ertn, 1'b1, 32'h0}, '{k_none, 1'b0, 32'h0},
      // except and ertn together
      '{k_both, 1'b1, 32'h0}, '{k_none, 1'b0, 32'h0},
      // misaligned target then out of range target
      '{k_br, 1'b0, 32'h0000_0042}, '{k_none, 1'b0, 32'h0},
      '{k_br, 1'b0, 32'h0000_0200}, '{k_none, 1'b0, 32'h0},
      '{k_br, 1'b1, 32'h0}, '{k_stall, 1'b0, 32'h0},
      '{k_none, 1'b0, 32'h0}, '{k_none, 1'b0, 32'h0},
      // drain the trace pipe
      '{k_none, 1'b0, 32'h0}, '{k_none, 1'b0, 32'h0},
      '{k_none, 1'b0, 32'h0}, '{k_none, 1'b0, 32'h0}
   };

   logic       clock;
   logic       rst_n;
   redirect_t  redir;
   fetch_pkt_t dec_pkt;
   pc_trace_t  trace;

   // own copy of the program image
   logic [grlen-1:0] rom_img [irom_words];
   // per-cycle predicted packet, for the trace checks
   logic             hist_valid [n_rows];
   logic [grlen-1:0] hist_pc [n_rows];

   tb_clock_gen clk_i (.clock(clock));

   cpu7_ifu dut_i (
      .clock   (clock),
      .rst_n   (rst_n),
      .redir   (redir),
      .dec_pkt (dec_pkt),
      .trace   (trace)
   );

   // ============================================================
   // helpers and reference model
   // ============================================================

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   // misaligned or past the rom
   function automatic logic addr_faults(input logic [grlen-1:0] a);
      return (a[1:0] != 2'b00) || (a >= grlen'(irom_bytes));
   endfunction

   // unused targets carry b so any leak of them shows up
   function automatic redirect_t make_redirect(input row_t row, input logic [grlen-1:0] a,
                                               input logic [grlen-1:0] b);
      redirect_t r;
      r = '0;
      r.br_target = b;
      r.eentry    = b;
      r.era       = b;
      case (row.kind)
         k_br: begin
            r.br_taken  = 1'b1;
            r.br_target = a;
         end
         k_exc: begin
            r.except = 1'b1;
            r.eentry = a;
         end
         k_ertn: begin
            r.ertn = 1'b1;
            r.era  = a;
         end
         k_stall: r.stall = 1'b1;
         k_both: begin
            r.except = 1'b1;
            r.eentry = a;
            r.ertn   = 1'b1;
         end
         default: r.stall = 1'b0;
      endcase
      return r;
   endfunction

   // except, ertn, branch, then hold, else step by 4
   function automatic logic [grlen-1:0] predict_next_pc(input redirect_t r,
                                                        input logic [grlen-1:0] pc,
                                                        input logic rsp);
      if (r.except) return r.eentry;
      else if (r.ertn) return r.era;
      else if (r.br_taken) return r.br_target;
      else if (r.stall || !rsp) return pc;
      else return pc + 32'd4;
   endfunction

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("RESULT: FAIL");
      $fatal(1, "run stopped");
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                  input logic [31:0] act_v);
      fail_run($sformatf("FAIL at %0t ns: %s expected %h got %h", $time, name, exp_v, act_v));
   endtask

   // ============================================================
   // watchdog
   // ============================================================

   initial begin
      #((n_rows + 20) * 100);
      fail_run("watchdog expired before the test table finished");
   end

   // ============================================================
   // main sequence
   // ============================================================

   initial begin
      logic [31:0]      seed;
      logic [grlen-1:0] a;
      logic [grlen-1:0] b;
      logic [grlen-1:0] m_pc;
      logic             m_rsp;
      logic             exp_valid;
      logic             exp_ex;
      logic [grlen-1:0] exp_inst;
      logic             e_exp;
      logic             w_exp;

      seed  = 32'h006460cb;
      redir = '0;
      rst_n = 1'b0;
      $readmemh("irom.hex", rom_img);
      // model state in the first cycle after reset
      m_pc  = reset_pc;
      m_rsp = 1'b0;

      repeat (2) @(posedge clock);
      #1 rst_n = 1'b1;

      for (int c = 0; c < n_rows; c++) begin
         @(posedge clock);
         #1;
         seed = xorshift32(seed);
         a    = rows[c].rnd ? (seed & 32'h0000_007c) : rows[c].addr;
         seed = xorshift32(seed);
         b    = seed & 32'h0000_007c;
         redir = make_redirect(rows[c], a, b);

         // this cycle's packet from the model
         exp_valid = m_rsp & ~redir.stall & ~redir.br_taken & ~redir.except & ~redir.ertn;
         exp_ex    = addr_faults(m_pc);
         exp_inst  = exp_ex ? '0 : rom_img[m_pc[irom_aw+1:2]];
         hist_valid[c] = exp_valid;
         hist_pc[c]    = m_pc;
         e_exp = (c >= 2) ? hist_valid[c-2] : 1'b0;
         w_exp = (c >= 4) ? hist_valid[c-4] : 1'b0;

         @(negedge clock);
         assert (dec_pkt.valid === exp_valid)
            else report_mismatch("dec_pkt.valid", exp_valid, dec_pkt.valid);
         assert (dec_pkt.pc === m_pc) else report_mismatch("dec_pkt.pc", m_pc, dec_pkt.pc);
         if (exp_valid) begin
            assert (dec_pkt.inst === exp_inst)
               else report_mismatch("dec_pkt.inst", exp_inst, dec_pkt.inst);
            assert (dec_pkt.ex === exp_ex) else report_mismatch("dec_pkt.ex", exp_ex, dec_pkt.ex);
            assert (dec_pkt.exccode === (exp_ex ? ecode_adef : 6'h00))
               else report_mismatch("dec_pkt.exccode", exp_ex ? ecode_adef : 6'h00,
                                    dec_pkt.exccode);
         end
         // trace lags decode by 2 and 4 cycles
         assert (trace.pc_e_valid === e_exp)
            else report_mismatch("trace.pc_e_valid", e_exp, trace.pc_e_valid);
         if (e_exp) begin
            assert (trace.pc_e === hist_pc[c-2])
               else report_mismatch("trace.pc_e", hist_pc[c-2], trace.pc_e);
         end
         assert (trace.pc_w_valid === w_exp)
            else report_mismatch("trace.pc_w_valid", w_exp, trace.pc_w_valid);
         if (w_exp) begin
            assert (trace.pc_w === hist_pc[c-4])
               else report_mismatch("trace.pc_w", hist_pc[c-4], trace.pc_w);
         end
         assert (dut_i.fdp_i.props_i.prop_fails == 0)
            else fail_run("a property check in the fetch datapath failed");

         m_pc  = predict_next_pc(redir, m_pc, m_rsp);
         m_rsp = 1'b1;
      end

      $display("RESULT: PASS");
      $finish;
   end

endmodule

//--- bench/cpu7_ifu_props.sv
`timescale 1ns/100ps

module cpu7_ifu_props (
   input logic                       clock,
   input logic                       rst_n,
   input cpu7_pkg::redirect_t        redir,
   input logic                       inst_req,
   input cpu7_pkg::fetch_pkt_t       dec_pkt,
   input logic [cpu7_pkg::grlen-1:0] pc_f
);

   import cpu7_pkg::*;

   // count of failed properties for the testbench to poll
   int prop_fails = 0;

   // no fetch request while reset is held
   req_in_reset: assert property (@(posedge clock) !rst_n |-> !inst_req)
      else begin
         $error("inst_req high during reset");
         prop_fails++;
      end

   // an exception sends the next fetch to eentry
   except_loads_eentry: assert property (@(posedge clock) disable iff (!rst_n)
      (inst_req && redir.except) |=> (pc_f == $past(redir.eentry)))
      else begin
         $error("pc_f did not move to eentry after an exception");
         prop_fails++;
      end

   // plain stall holds the fetch pc
   stall_holds_pc: assert property (@(posedge clock) disable iff (!rst_n)
      (redir.stall && !(redir.br_taken || redir.except || redir.ertn)) |=> $stable(pc_f))
      else begin
         $error("pc_f moved during a stall");
         prop_fails++;
      end

endmodule

bind cpu7_ifu_fdp cpu7_ifu_props props_i (
   .clock    (clock),
   .rst_n    (rst_n),
   .redir    (redir),
   .inst_req (inst_req),
   .dec_pkt  (dec_pkt),
   .pc_f     (pc_f)
);

//--- bench/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
   output logic clock
);

   // 100 ns period, first rising edge at 50 ns
   localparam int half_period = 50;

   initial begin
      clock = 1'b0;
      forever #half_period clock = ~clock;
   end

endmodule

//--- design/cpu7_ifu.sv
`timescale 1ns/100ps

module cpu7_ifu (
   input  logic                 clock,
   input  logic                 rst_n,
   input  cpu7_pkg::redirect_t  redir,
   output cpu7_pkg::fetch_pkt_t dec_pkt,
   output cpu7_pkg::pc_trace_t  trace
);

   import cpu7_pkg::*;

   // fetch request bus
   logic               inst_req;
   logic [grlen-1:0]   inst_addr;
   logic               inst_cancel;
   logic               inst_addr_ok;
   logic               inst_valid_f;
   logic               inst_ex;
   logic [ecode_w-1:0] inst_exccode;
   logic [grlen-1:0]   inst_rdata_f;
   // rom port
   logic [irom_aw-1:0] rom_addr;
   logic [grlen-1:0]   rom_data;

   // ============================================================
   // fetch datapath and bus bridge
   // ============================================================

   cpu7_ifu_fdp fdp_i (
      .clock        (clock),
      .rst_n        (rst_n),
      .redir        (redir),
      .inst_req     (inst_req),
      .inst_addr    (inst_addr),
      .inst_cancel  (inst_cancel),
      .inst_addr_ok (inst_addr_ok),
      .inst_valid_f (inst_valid_f),
      .inst_ex      (inst_ex),
      .inst_exccode (inst_exccode),
      .inst_rdata_f (inst_rdata_f),
      .dec_pkt      (dec_pkt)
   );

   cpu7_ifu_ibus ibus_i (
      .clock        (clock),
      .rst_n        (rst_n),
      .inst_req     (inst_req),
      .inst_addr    (inst_addr),
      .inst_cancel  (inst_cancel),
      .inst_addr_ok (inst_addr_ok),
      .inst_valid_f (inst_valid_f),
      .inst_rdata_f (inst_rdata_f),
      .inst_ex      (inst_ex),
      .inst_exccode (inst_exccode),
      .rom_addr     (rom_addr),
      .rom_data     (rom_data)
   );

   // ============================================================
   // program store and pc tracking
   // ============================================================

   cpu7_irom irom_i (
      .clock (clock),
      .addr  (rom_addr),
      .data  (rom_data)
   );

   // follows each decoded pc down to writeback
   cpu7_ifu_pcpipe pcpipe_i (
      .clock   (clock),
      .rst_n   (rst_n),
      .dec_pkt (dec_pkt),
      .trace   (trace)
   );

endmodule

//--- design/cpu7_ifu_pcpipe.sv
`timescale 1ns/100ps

module cpu7_ifu_pcpipe (
   input  logic                 clock,
   input  logic                 rst_n,
   input  cpu7_pkg::fetch_pkt_t dec_pkt,
   output cpu7_pkg::pc_trace_t  trace
);

   import cpu7_pkg::*;

   // pc per stage
   logic [grlen-1:0] pc_d;
   logic [grlen-1:0] pc_e;
   logic [grlen-1:0] pc_m;
   logic [grlen-1:0] pc_w;
   // valid per stage
   logic             d_valid;
   logic             e_valid;
   logic             m_valid;
   logic             w_valid;

   // ============================================================
   // valid chain
   // ============================================================

   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         d_valid <= 1'b0;
         e_valid <= 1'b0;
         m_valid <= 1'b0;
         w_valid <= 1'b0;
      end else begin
         // decode slot empties on a masked packet
         d_valid <= dec_pkt.valid;
         e_valid <= d_valid;
         m_valid <= e_valid;
         w_valid <= m_valid;
      end
   end

   // pc chain, decode only takes valid packets
   always_ff @(posedge clock) begin
      if (dec_pkt.valid) begin
         pc_d <= dec_pkt.pc;
      end
      pc_e <= pc_d;
      pc_m <= pc_e;
      pc_w <= pc_m;
   end

   // execute and writeback views
   assign trace.pc_e       = pc_e;
   assign trace.pc_e_valid = e_valid;
   assign trace.pc_w       = pc_w;
   assign trace.pc_w_valid = w_valid;

endmodule

//--- design/cpu7_irom.sv
`timescale 1ns/100ps

module cpu7_irom (
   input  logic                         clock,
   input  logic [cpu7_pkg::irom_aw-1:0] addr,
   output logic [cpu7_pkg::grlen-1:0]   data
);

   import cpu7_pkg::*;

   // program image, one word per entry
   logic [grlen-1:0] mem [irom_words];

   // contents come from the hex image
   initial begin
      $readmemh("irom.hex", mem);
   end

   // ============================================================
   // registered read
   // ============================================================

   // data one cycle after the address
   always_ff @(posedge clock) begin
      data <= mem[addr];
   end

endmodule

//--- design/cpu7_ifu_ibus.sv
`timescale 1ns/100ps

module cpu7_ifu_ibus (
   input  logic                         clock,
   input  logic                         rst_n,
   // request from the fetch datapath
   input  logic                         inst_req,
   input  logic [cpu7_pkg::grlen-1:0]   inst_addr,
   input  logic                         inst_cancel,
   // response back to it
   output logic                         inst_addr_ok,
   output logic                         inst_valid_f,
   output logic [cpu7_pkg::grlen-1:0]   inst_rdata_f,
   output logic                         inst_ex,
   output logic [cpu7_pkg::ecode_w-1:0] inst_exccode,
   // rom side
   output logic [cpu7_pkg::irom_aw-1:0] rom_addr,
   input  logic [cpu7_pkg::grlen-1:0]   rom_data
);

   import cpu7_pkg::*;

   logic req_acc;
   logic addr_err;
   logic rsp_valid_q;
   logic rsp_err_q;

   // ============================================================
   // request side
   // ============================================================

   // single-cycle rom, so every request is taken
   assign inst_addr_ok = 1'b1;
   assign req_acc      = inst_req & inst_addr_ok;

   // misaligned, or past the end of the rom
   assign addr_err = (|inst_addr[1:0]) | (inst_addr >= grlen'(irom_bytes));

   // word index, rom registers it
   assign rom_addr = inst_addr[irom_aw+1:2];

   // ============================================================
   // response side
   // ============================================================

   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         rsp_valid_q <= 1'b0;
         rsp_err_q   <= 1'b0;
      end else begin
         rsp_valid_q <= req_acc;
         // error only tagged on a real request
         rsp_err_q   <= req_acc & addr_err;
      end
   end

   // response overtaken by a redirect is dropped here
   assign inst_valid_f = rsp_valid_q & ~inst_cancel;

   assign inst_ex      = rsp_err_q;
   assign inst_exccode = rsp_err_q ? ecode_adef : '0;
   // no rom data for a faulting fetch
   assign inst_rdata_f = rsp_err_q ? '0 : rom_data;

endmodule

//--- design/cpu7_ifu_fdp.sv
`timescale 1ns/100ps

module cpu7_ifu_fdp (
   input  logic                         clock,
   input  logic                         rst_n,
   input  cpu7_pkg::redirect_t          redir,
   // fetch request side
   output logic                         inst_req,
   output logic [cpu7_pkg::grlen-1:0]   inst_addr,
   output logic                         inst_cancel,
   input  logic                         inst_addr_ok,
   input  logic                         inst_valid_f,
   input  logic                         inst_ex,
   input  logic [cpu7_pkg::ecode_w-1:0] inst_exccode,
   input  logic [cpu7_pkg::grlen-1:0]   inst_rdata_f,
   // to decode
   output cpu7_pkg::fetch_pkt_t         dec_pkt
);

   import cpu7_pkg::*;

   logic             started;
   logic             pc_f_en;
   logic [grlen-1:0] pc_bf;
   logic [grlen-1:0] pc_f;
   logic [grlen-3:0] pcinc_word;
   logic [grlen-1:0] pcinc_f;

   // ============================================================
   // fetch control
   // ============================================================

   // set on the first edge after reset, then stays
   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         started <= 1'b0;
      end else begin
         started <= 1'b1;
      end
   end

   // request every cycle once running
   assign inst_req = started;

   // any redirect kills the response now on the bus
   assign inst_cancel = redir.br_taken | redir.except | redir.ertn;

   // ============================================================
   // pc datapath
   // ============================================================

   // word increment, byte offset carried through
   assign pcinc_word = pc_f[grlen-1:2] + 1'b1;
   assign pcinc_f    = {pcinc_word, pc_f[1:0]};

   // next pc, highest priority first
   always_comb begin
      if (!started) begin
         pc_bf = reset_pc;
      end else if (redir.except) begin
         pc_bf = redir.eentry;
      end else if (redir.ertn) begin
         pc_bf = redir.era;
      end else if (redir.br_taken) begin
         pc_bf = redir.br_target;
      end else if (redir.stall || !inst_valid_f) begin
         // repeat the same fetch
         pc_bf = pc_f;
      end else begin
         pc_bf = pcinc_f;
      end
   end

   // pc_bf goes straight out as the request address
   assign inst_addr = pc_bf;

   // load on an accepted request, or the reset pc before start
   assign pc_f_en = ~started | (inst_req & inst_addr_ok);

   always_ff @(posedge clock) begin
      if (pc_f_en) begin
         pc_f <= pc_bf;
      end
   end

   // ============================================================
   // decode packet
   // ============================================================

   // nothing passes under a stall or a redirect
   assign dec_pkt.valid   = inst_valid_f & ~redir.stall & ~inst_cancel;
   assign dec_pkt.ex      = inst_ex;
   assign dec_pkt.exccode = inst_exccode;
   assign dec_pkt.inst    = inst_rdata_f;
   // pc_f is the address of the word on the bus
   assign dec_pkt.pc      = pc_f;

endmodule

//--- design/cpu7_pkg.sv
package cpu7_pkg;

   // ============================================================
   // widths and fixed addresses
   // ============================================================

   // datapath width
   localparam int grlen = 32;
   // first fetch after reset
   localparam logic [grlen-1:0] reset_pc = 32'h0000_0000;

   // rom depth in words, and its byte span
   localparam int irom_words = 32;
   localparam int irom_aw    = $clog2(irom_words);
   localparam int irom_bytes = irom_words * 4;

   // exception codes
   localparam int ecode_w = 6;
   localparam logic [ecode_w-1:0] ecode_adef = 6'h08;

   // ============================================================
   // structs between the fetch unit and its neighbours
   // ============================================================

   // redirect and back-pressure from the execution unit
   typedef struct packed {
      logic             br_taken;
      logic [grlen-1:0] br_target;
      logic             except;
      logic [grlen-1:0] eentry;
      logic             ertn;
      logic [grlen-1:0] era;
      logic             stall;
   } redirect_t;

   // one fetched instruction towards decode
   typedef struct packed {
      logic               valid;
      logic               ex;
      logic [ecode_w-1:0] exccode;
      logic [grlen-1:0]   inst;
      logic [grlen-1:0]   pc;
   } fetch_pkt_t;

   // pc of the instructions in execute and writeback
   typedef struct packed {
      logic [grlen-1:0] pc_e;
      logic             pc_e_valid;
      logic [grlen-1:0] pc_w;
      logic             pc_w_valid;
   } pc_trace_t;

endpackage
